// File: dv/ps_sys_properties.sv
/*
 * Concurrent protocol checks on the AXI port and the internal system bus.
 * Bound into ps_sys_top from the testbench top.
 */

`timescale 1ns/1ps
`default_nettype none

module ps_sys_properties (
  input wire                       clk_i,
  input wire                       arst_n_i,
  input wire ps_sys_pkg::axi_aw_t  aw_i,
  input wire                       awready_i,
  input wire                       bready_i,
  input wire                       rready_i,
  input wire ps_sys_pkg::axi_b_t   b_i,
  input wire ps_sys_pkg::axi_r_t   r_i,
  input wire ps_sys_pkg::sys_req_t sys_req_i,
  input wire ps_sys_pkg::sys_rsp_t sys_rsp_i
);

  ////////////////////////////////////////////////////////////////////////////
  // AXI response channels
  ////////////////////////////////////////////////////////////////////////////

  b_valid_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    b_i.valid && !bready_i |=> b_i.valid)
    else $error("write response valid dropped before bready");

  r_valid_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    r_i.valid && !rready_i |=> r_i.valid)
    else $error("read response valid dropped before rready");

  // Data and code frozen during a stall
  r_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    r_i.valid && !rready_i |=> $stable(r_i))
    else $error("read response changed while stalled");

  // Handshake, then strobe, ack, and response on the third cycle
  b_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    aw_i.valid && awready_i |=> !b_i.valid ##1 !b_i.valid ##1 b_i.valid)
    else $error("write response not three cycles after address handshake");

  ////////////////////////////////////////////////////////////////////////////
  // System bus
  ////////////////////////////////////////////////////////////////////////////

  ack_after_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    sys_rsp_i.ack |-> $past(sys_req_i.wen || sys_req_i.ren))
    else $error("system bus ack without a strobe one cycle earlier");

endmodule

`default_nettype wire

// File: dv/ps_sys_tb.sv
/*
 * Testbench top for the register subsystem. Acts as the AXI master with
 * random response stalls, drives GPIO pins and interrupt sources, and
 * compares every answer with a small model of the register map.
 */

`timescale 1ns/1ps
`default_nettype none

module ps_sys_tb;

  localparam int GPIO_W = 8;
  localparam int IRQ_N  = 4;
  // About 64 transfers of at most ~16 cycles each, times 4 for stalls
  localparam int MAX_CYCLES = 4000;

  localparam logic [31:0] GPIO_BASE = 32'h0000_0000;
  localparam logic [31:0] IRQ_BASE  = 32'h0001_0000;
  localparam logic [31:0] BAD_BASE  = 32'h0005_0000;
  localparam logic [31:0] GPIO_MASK = (32'd1 << GPIO_W) - 32'd1;

  // AXI response codes
  localparam logic [31:0] RSP_OKAY   = 32'h0;
  localparam logic [31:0] RSP_SLVERR = 32'h2;
  localparam logic [31:0] RSP_DECERR = 32'h3;

  logic                clk;
  logic                arst_n;
  ps_sys_pkg::axi_aw_t aw;
  ps_sys_pkg::axi_w_t  w;
  ps_sys_pkg::axi_ar_t ar;
  logic                bready;
  logic                rready;
  logic                awready;
  logic                wready;
  logic                arready;
  ps_sys_pkg::axi_b_t  b;
  ps_sys_pkg::axi_r_t  r;
  logic [GPIO_W-1:0]   gpio_in;
  logic [GPIO_W-1:0]   gpio_out;
  logic [GPIO_W-1:0]   gpio_t;
  logic [IRQ_N-1:0]    irq_src;
  logic                irq;
  logic [15:0]         lfsr_q;
  int                  cycles = 0;
  // Model of OUT and DIR
  logic [31:0]         out_m;
  logic [31:0]         dir_m;

  tb_clock clk0 (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  ps_sys_top #(
    .GPIO_W (GPIO_W),
    .IRQ_N  (IRQ_N)
  ) dut0 (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .aw_i      (aw),
    .w_i       (w),
    .ar_i      (ar),
    .bready_i  (bready),
    .rready_i  (rready),
    .awready_o (awready),
    .wready_o  (wready),
    .arready_o (arready),
    .b_o       (b),
    .r_o       (r),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_t_o  (gpio_t),
    .irq_src_i (irq_src),
    .irq_o     (irq)
  );

  bind ps_sys_top ps_sys_properties props0 (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .aw_i      (aw_i),
    .awready_i (awready_o),
    .bready_i  (bready_i),
    .rready_i  (rready_i),
    .b_i       (b_o),
    .r_i       (r_o),
    .sys_req_i (sys_req),
    .sys_rsp_i (sys_rsp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Checking and random bits
  ////////////////////////////////////////////////////////////////////////////

  task automatic halt_run();
    $display("Something failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      halt_run();
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic        fb;
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      bits   = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic logic [31:0] apply_strobes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old & ~mask) | (data & mask);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // AXI master
  ////////////////////////////////////////////////////////////////////////////

  // Each task leaves the caller on a falling edge
  task automatic push_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    @(negedge clk);
    aw.addr  = addr;
    aw.valid = 1'b1;
    w.data   = data;
    w.strb   = strb;
    w.valid  = 1'b1;
    #1;
    while (!awready) begin
      @(negedge clk);
      #1;
    end
    // Data channel taken in the same cycle as the address
    check_eq("wready_o", 32'(wready), 32'h1);
    @(negedge clk);
    aw.valid = 1'b0;
    w.valid  = 1'b0;
  endtask

  task automatic push_read(input logic [31:0] addr);
    @(negedge clk);
    ar.addr  = addr;
    ar.valid = 1'b1;
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    ar.valid = 1'b0;
  endtask

  // Random bready, about one stall in four
  task automatic pull_b(output logic [1:0] resp);
    logic [31:0] bits;
    logic        done;
    done = 1'b0;
    while (!done) begin
      bits   = take_bits(2);
      bready = |bits[1:0];
      #1;
      check_eq("r_o.valid", 32'(r.valid), 32'h0);
      if (b.valid && bready) begin
        resp = b.resp;
        done = 1'b1;
      end
      @(negedge clk);
    end
    bready = 1'b0;
  endtask

  task automatic pull_r(output logic [31:0] data, output logic [1:0] resp);
    logic [31:0] bits;
    logic        done;
    done = 1'b0;
    while (!done) begin
      bits   = take_bits(2);
      rready = |bits[1:0];
      #1;
      check_eq("b_o.valid", 32'(b.valid), 32'h0);
      if (r.valid && rready) begin
        data = r.data;
        resp = r.resp;
        done = 1'b1;
      end
      @(negedge clk);
    end
    rready = 1'b0;
  endtask

  task automatic write_expect(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic [31:0] exp_resp);
    logic [1:0] resp;
    push_write(addr, data, strb);
    pull_b(resp);
    check_eq("b_o.resp", 32'(resp), exp_resp);
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp_data,
                             input logic [31:0] exp_resp, input logic check_data);
    logic [31:0] data;
    logic [1:0]  resp;
    push_read(addr);
    pull_r(data, resp);
    check_eq("r_o.resp", 32'(resp), exp_resp);
    if (check_data) begin
      check_eq("r_o.data", data, exp_data);
    end
  endtask

  // Write and read offered together, the write must go first
  task automatic write_then_read(input logic [31:0] addr, input logic [31:0] data);
    logic [1:0]  wresp;
    logic [1:0]  rresp;
    logic [31:0] rdata;
    @(negedge clk);
    aw.addr  = addr;
    aw.valid = 1'b1;
    w.data   = data;
    w.strb   = 4'hF;
    w.valid  = 1'b1;
    ar.addr  = addr;
    ar.valid = 1'b1;
    #1;
    check_eq("arready_o", 32'(arready), 32'h0);
    check_eq("awready_o", 32'(awready), 32'h1);
    check_eq("wready_o", 32'(wready), 32'h1);
    @(negedge clk);
    aw.valid = 1'b0;
    w.valid  = 1'b0;
    pull_b(wresp);
    check_eq("b_o.resp", 32'(wresp), RSP_OKAY);
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    ar.valid = 1'b0;
    pull_r(rdata, rresp);
    out_m = apply_strobes(out_m, data, 4'hF);
    check_eq("r_o.resp", 32'(rresp), RSP_OKAY);
    check_eq("r_o.data", rdata, out_m & GPIO_MASK);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic gpio_reg_readback();
    logic [31:0] bits;
    logic [31:0] data;
    logic [3:0]  strb;
    for (int i = 0; i < 8; i++) begin
      data = take_bits(32);
      bits = take_bits(4);
      strb = bits[3:0];
      write_expect(GPIO_BASE, data, strb, RSP_OKAY);
      out_m = apply_strobes(out_m, data, strb);
      data = take_bits(32);
      bits = take_bits(4);
      strb = bits[3:0];
      write_expect(GPIO_BASE + 32'h4, data, strb, RSP_OKAY);
      dir_m = apply_strobes(dir_m, data, strb);
      read_expect(GPIO_BASE, out_m & GPIO_MASK, RSP_OKAY, 1'b1);
      read_expect(GPIO_BASE + 32'h4, dir_m & GPIO_MASK, RSP_OKAY, 1'b1);
      #1;
      check_eq("gpio_o", 32'(gpio_out), out_m & GPIO_MASK);
      // 1 in DIR drives the pin
      check_eq("gpio_t_o", 32'(gpio_t), ~dir_m & GPIO_MASK);
    end
  endtask

  task automatic gpio_input_sampling();
    logic [31:0] bits;
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      bits    = take_bits(GPIO_W);
      gpio_in = bits[GPIO_W-1:0];
      // Two synchronizer stages plus margin
      repeat (3) @(negedge clk);
      read_expect(GPIO_BASE + 32'h8, bits & GPIO_MASK, RSP_OKAY, 1'b1);
    end
  endtask

  // One-cycle pulse, irq_o expected two cycles after the edge
  task automatic fire_source(input logic [IRQ_N-1:0] mask, input logic exp_irq);
    @(negedge clk);
    irq_src = mask;
    @(negedge clk);
    irq_src = '0;
    #1;
    check_eq("irq_o", 32'(irq), 32'h0);
    @(negedge clk);
    #1;
    check_eq("irq_o", 32'(irq), 32'(exp_irq));
  endtask

  task automatic interrupt_sequence();
    // Sources 0 and 2 enabled
    write_expect(IRQ_BASE, 32'h5, 4'h1, RSP_OKAY);
    read_expect(IRQ_BASE, 32'h5, RSP_OKAY, 1'b1);
    fire_source(4'b0001, 1'b1);
    read_expect(IRQ_BASE + 32'h4, 32'h1, RSP_OKAY, 1'b1);
    #1;
    check_eq("irq_o", 32'(irq), 32'h1);
    write_expect(IRQ_BASE + 32'h4, 32'h1, 4'h1, RSP_OKAY);
    #1;
    check_eq("irq_o", 32'(irq), 32'h0);
    read_expect(IRQ_BASE + 32'h4, 32'h0, RSP_OKAY, 1'b1);
    // Masked source still sticky
    fire_source(4'b0010, 1'b0);
    read_expect(IRQ_BASE + 32'h4, 32'h2, RSP_OKAY, 1'b1);
    #1;
    check_eq("irq_o", 32'(irq), 32'h0);
    write_expect(IRQ_BASE + 32'h4, 32'h2, 4'h1, RSP_OKAY);
    read_expect(IRQ_BASE + 32'h4, 32'h0, RSP_OKAY, 1'b1);
  endtask

  task automatic error_responses();
    read_expect(BAD_BASE, 32'h0, RSP_DECERR, 1'b1);
    write_expect(BAD_BASE + 32'h4, 32'hFFFF_FFFF, 4'hF, RSP_DECERR);
    write_expect(GPIO_BASE + 32'h8, 32'h55, 4'hF, RSP_SLVERR);
    write_expect(GPIO_BASE + 32'hC, 32'h55, 4'hF, RSP_SLVERR);
    read_expect(GPIO_BASE + 32'hC, 32'h0, RSP_SLVERR, 1'b0);
    write_expect(IRQ_BASE + 32'hC, 32'h1, 4'hF, RSP_SLVERR);
    read_expect(IRQ_BASE + 32'hC, 32'h0, RSP_SLVERR, 1'b0);
  endtask

  task automatic stall_ordering();
    logic [31:0] data;
    for (int i = 0; i < 4; i++) begin
      data = take_bits(32);
      write_then_read(GPIO_BASE, data);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and timeout
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    aw      = '0;
    w       = '0;
    ar      = '0;
    bready  = 1'b0;
    rready  = 1'b0;
    gpio_in = '0;
    irq_src = '0;
    lfsr_q  = 16'd6785;
    out_m   = '0;
    dir_m   = '0;
    wait (arst_n === 1'b1);
    #1;
    // Quiet outputs and undriven pins out of reset
    check_eq("awready_o", 32'(awready), 32'h0);
    check_eq("wready_o", 32'(wready), 32'h0);
    check_eq("arready_o", 32'(arready), 32'h0);
    check_eq("b_o.valid", 32'(b.valid), 32'h0);
    check_eq("r_o.valid", 32'(r.valid), 32'h0);
    check_eq("irq_o", 32'(irq), 32'h0);
    check_eq("gpio_t_o", 32'(gpio_t), GPIO_MASK);
    gpio_reg_readback();
    gpio_input_sampling();
    interrupt_sequence();
    error_responses();
    stall_ordering();
    $display("Everything OK");
    $finish;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      halt_run();
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
/*
 * Clock and reset source for the testbench. 8 ns clock, active-low reset
 * held for 4 cycles and released on a falling edge.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int HALF_PERIOD  = 4,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: hdl/axi_sys_slave.sv
/*
 * Single-beat AXI slave that turns each transfer into system-bus strobes.
 * One transfer in flight at a time; a write wins over a pending read.
 * The response is held on b_o or r_o until the master takes it.
 */

`timescale 1ns/1ps
`default_nettype none

module axi_sys_slave (
  input  wire                  clk_i,
  input  wire                  arst_n_i,
  // AXI master side
  input  wire ps_sys_pkg::axi_aw_t aw_i,
  input  wire ps_sys_pkg::axi_w_t  w_i,
  input  wire ps_sys_pkg::axi_ar_t ar_i,
  input  wire                  bready_i,
  input  wire                  rready_i,
  output logic                 awready_o,
  output logic                 wready_o,
  output logic                 arready_o,
  output ps_sys_pkg::axi_b_t   b_o,
  output ps_sys_pkg::axi_r_t   r_o,
  // System bus
  output ps_sys_pkg::sys_req_t sys_req_o,
  input  wire ps_sys_pkg::sys_rsp_t sys_rsp_i,
  input  wire                  decerr_i
);

  ps_sys_pkg::axi_state_e state_q;
  ps_sys_pkg::axi_state_e state_d;

  // Captured transfer
  logic [ps_sys_pkg::ADDR_W-1:0] addr_q;
  logic [ps_sys_pkg::DATA_W-1:0] wdata_q;
  logic [3:0]                    wsel_q;
  logic                          is_wr_q;

  // Captured response
  logic [ps_sys_pkg::DATA_W-1:0] rdata_q;
  ps_sys_pkg::axi_resp_e         resp_q;

  logic wr_hs;
  logic rd_hs;
  logic idle;

  ////////////////////////////////////////////////////////////////////////////
  // Address acceptance
  ////////////////////////////////////////////////////////////////////////////

  assign idle = (state_q == ps_sys_pkg::ST_IDLE);

  // Address and data taken together in one cycle
  assign awready_o = idle && aw_i.valid && w_i.valid;
  assign wready_o  = awready_o;
  // Read only when no complete write is waiting
  assign arready_o = idle && ar_i.valid && !(aw_i.valid && w_i.valid);

  assign wr_hs = awready_o;
  assign rd_hs = arready_o;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ps_sys_pkg::ST_IDLE: begin
        if (wr_hs) begin
          state_d = ps_sys_pkg::ST_WR_REQ;
        end else if (rd_hs) begin
          state_d = ps_sys_pkg::ST_RD_REQ;
        end
      end
      // Strobe lasts exactly one cycle
      ps_sys_pkg::ST_WR_REQ,
      ps_sys_pkg::ST_RD_REQ: begin
        state_d = ps_sys_pkg::ST_WAIT_ACK;
      end
      ps_sys_pkg::ST_WAIT_ACK: begin
        if (sys_rsp_i.ack) begin
          state_d = is_wr_q ? ps_sys_pkg::ST_B_RESP : ps_sys_pkg::ST_R_RESP;
        end
      end
      // Back-pressure holds the response
      ps_sys_pkg::ST_B_RESP: begin
        if (bready_i) begin
          state_d = ps_sys_pkg::ST_IDLE;
        end
      end
      ps_sys_pkg::ST_R_RESP: begin
        if (rready_i) begin
          state_d = ps_sys_pkg::ST_IDLE;
        end
      end
      default: begin
        state_d = ps_sys_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ps_sys_pkg::ST_IDLE;
      is_wr_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (wr_hs || rd_hs) begin
        is_wr_q <= wr_hs;
      end
    end
  end

  // Transfer and response payload
  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      addr_q  <= aw_i.addr;
      wdata_q <= w_i.data;
      wsel_q  <= w_i.strb;
    end else if (rd_hs) begin
      addr_q  <= ar_i.addr;
    end
    if (state_q == ps_sys_pkg::ST_WAIT_ACK && sys_rsp_i.ack) begin
      rdata_q <= sys_rsp_i.rdata;
      // Decoder flags unmapped regions, anything else is a slave error
      if (!sys_rsp_i.err) begin
        resp_q <= ps_sys_pkg::RESP_OKAY;
      end else if (decerr_i) begin
        resp_q <= ps_sys_pkg::RESP_DECERR;
      end else begin
        resp_q <= ps_sys_pkg::RESP_SLVERR;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sys_req_o.addr  = addr_q;
    sys_req_o.wdata = wdata_q;
    sys_req_o.wsel  = wsel_q;
    sys_req_o.wen   = (state_q == ps_sys_pkg::ST_WR_REQ);
    sys_req_o.ren   = (state_q == ps_sys_pkg::ST_RD_REQ);
  end

  always_comb begin
    b_o.resp  = resp_q;
    b_o.valid = (state_q == ps_sys_pkg::ST_B_RESP);
    r_o.data  = rdata_q;
    r_o.resp  = resp_q;
    r_o.valid = (state_q == ps_sys_pkg::ST_R_RESP);
  end

endmodule

`default_nettype wire

// File: hdl/gpio_regs.sv
/*
 * GPIO register block. OUT at 0x0, DIR at 0x4 (1 drives the pin),
 * IN at 0x8 read-only through a two-flop synchronizer.
 */

`timescale 1ns/1ps
`default_nettype none

module gpio_regs #(
  parameter int GPIO_W = 8
) (
  input  wire                  clk_i,
  input  wire                  arst_n_i,
  input  wire ps_sys_pkg::sys_req_t req_i,
  output ps_sys_pkg::sys_rsp_t rsp_o,
  input  wire [GPIO_W-1:0]     gpio_i,
  output logic [GPIO_W-1:0]    gpio_o,
  output logic [GPIO_W-1:0]    gpio_t_o
);

  localparam logic [15:0] OFF_OUT = 16'h0;
  localparam logic [15:0] OFF_DIR = 16'h4;
  localparam logic [15:0] OFF_IN  = 16'h8;

  logic [15:0]                   off;
  logic                          hit_out;
  logic                          hit_dir;
  logic                          hit_in;
  logic [ps_sys_pkg::DATA_W-1:0] bmask;
  logic [GPIO_W-1:0]             wmask;
  logic [GPIO_W-1:0]             wval;
  logic [GPIO_W-1:0]             out_q;
  logic [GPIO_W-1:0]             dir_q;
  logic [GPIO_W-1:0]             sync1_q;
  logic [GPIO_W-1:0]             sync2_q;
  logic [ps_sys_pkg::DATA_W-1:0] rd_val;
  logic [ps_sys_pkg::DATA_W-1:0] rdata_q;
  logic                          ack_q;
  logic                          err_q;

  assign off     = req_i.addr[15:0];
  assign hit_out = (off == OFF_OUT);
  assign hit_dir = (off == OFF_DIR);
  assign hit_in  = (off == OFF_IN);
  assign bmask   = ps_sys_pkg::strb_mask(req_i.wsel);
  assign wmask   = bmask[GPIO_W-1:0];
  assign wval    = req_i.wdata[GPIO_W-1:0];

  // Pins start undriven
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q <= '0;
      dir_q <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_i.wen || req_i.ren;
      if (req_i.wen && hit_out) begin
        out_q <= (out_q & ~wmask) | (wval & wmask);
      end
      if (req_i.wen && hit_dir) begin
        dir_q <= (dir_q & ~wmask) | (wval & wmask);
      end
    end
  end

  // Read mux
  always_comb begin
    rd_val = '0;
    if (hit_out) begin
      rd_val[GPIO_W-1:0] = out_q;
    end else if (hit_dir) begin
      rd_val[GPIO_W-1:0] = dir_q;
    end else if (hit_in) begin
      rd_val[GPIO_W-1:0] = sync2_q;
    end
  end

  always_ff @(posedge clk_i) begin
    // Input synchronizer
    sync1_q <= gpio_i;
    sync2_q <= sync1_q;
    if (req_i.ren) begin
      rdata_q <= rd_val;
    end
    // IN is read-only
    err_q <= (req_i.wen && !(hit_out || hit_dir))
          || (req_i.ren && !(hit_out || hit_dir || hit_in));
  end

  always_comb begin
    rsp_o.rdata = rdata_q;
    rsp_o.ack   = ack_q;
    rsp_o.err   = err_q;
  end

  assign gpio_o   = out_q;
  assign gpio_t_o = ~dir_q;

endmodule

`default_nettype wire

// File: hdl/irq_ctrl.sv
/*
 * Interrupt controller. ENABLE at 0x0, sticky STATUS at 0x4 set by rising
 * source edges and cleared by writing 1. irq_o is a registered OR of the
 * enabled status bits.
 */

`timescale 1ns/1ps
`default_nettype none

module irq_ctrl #(
  parameter int IRQ_N = 4
) (
  input  wire                  clk_i,
  input  wire                  arst_n_i,
  input  wire ps_sys_pkg::sys_req_t req_i,
  output ps_sys_pkg::sys_rsp_t rsp_o,
  input  wire [IRQ_N-1:0]      irq_src_i,
  output logic                 irq_o
);

  localparam logic [15:0] OFF_EN   = 16'h0;
  localparam logic [15:0] OFF_STAT = 16'h4;

  logic [15:0]                   off;
  logic                          hit_en;
  logic                          hit_stat;
  logic [ps_sys_pkg::DATA_W-1:0] bmask;
  logic [IRQ_N-1:0]              wmask;
  logic [IRQ_N-1:0]              wval;
  logic [IRQ_N-1:0]              src_q;
  logic [IRQ_N-1:0]              rise;
  logic [IRQ_N-1:0]              clr;
  logic [IRQ_N-1:0]              en_q;
  logic [IRQ_N-1:0]              stat_q;
  logic                          irq_q;
  logic [ps_sys_pkg::DATA_W-1:0] rd_val;
  logic [ps_sys_pkg::DATA_W-1:0] rdata_q;
  logic                          ack_q;
  logic                          err_q;

  assign off      = req_i.addr[15:0];
  assign hit_en   = (off == OFF_EN);
  assign hit_stat = (off == OFF_STAT);
  assign bmask    = ps_sys_pkg::strb_mask(req_i.wsel);
  assign wmask    = bmask[IRQ_N-1:0];
  assign wval     = req_i.wdata[IRQ_N-1:0];

  // Rising edge against last cycle's level
  assign rise = irq_src_i & ~src_q;
  // Write-1 clear
  assign clr  = (req_i.wen && hit_stat) ? (wval & wmask) : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q  <= '0;
      en_q   <= '0;
      stat_q <= '0;
      irq_q  <= 1'b0;
      ack_q  <= 1'b0;
    end else begin
      src_q <= irq_src_i;
      ack_q <= req_i.wen || req_i.ren;
      if (req_i.wen && hit_en) begin
        en_q <= (en_q & ~wmask) | (wval & wmask);
      end
      // New edge wins over a clear
      stat_q <= (stat_q & ~clr) | rise;
      irq_q  <= |(stat_q & en_q);
    end
  end

  always_comb begin
    rd_val = '0;
    if (hit_en) begin
      rd_val[IRQ_N-1:0] = en_q;
    end else if (hit_stat) begin
      rd_val[IRQ_N-1:0] = stat_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.ren) begin
      rdata_q <= rd_val;
    end
    err_q <= (req_i.wen || req_i.ren) && !(hit_en || hit_stat);
  end

  always_comb begin
    rsp_o.rdata = rdata_q;
    rsp_o.ack   = ack_q;
    rsp_o.err   = err_q;
  end

  assign irq_o = irq_q;

endmodule

`default_nettype wire

// File: hdl/ps_sys_pkg.sv
/*
 * Shared types and constants for the processor-system register subsystem.
 * Holds the single-beat AXI channel structs, the system-bus request and
 * response structs, the slave FSM states and the address map.
 */

`default_nettype none

package ps_sys_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and address map
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Address bits 19:16 select the register block
  localparam logic [3:0] REGION_GPIO = 4'd0;
  localparam logic [3:0] REGION_IRQ  = 4'd1;

  ////////////////////////////////////////////////////////////////////////////
  // AXI side
  ////////////////////////////////////////////////////////////////////////////

  // Response codes as on the AXI wire
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_REQ,
    ST_RD_REQ,
    ST_WAIT_ACK,
    ST_B_RESP,
    ST_R_RESP
  } axi_state_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              valid;
  } axi_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [3:0]        strb;
    logic              valid;
  } axi_w_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              valid;
  } axi_ar_t;

  typedef struct packed {
    axi_resp_e resp;
    logic      valid;
  } axi_b_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    axi_resp_e         resp;
    logic              valid;
  } axi_r_t;

  ////////////////////////////////////////////////////////////////////////////
  // System bus
  ////////////////////////////////////////////////////////////////////////////

  // wen and ren are single-cycle strobes
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [3:0]        wsel;
    logic              wen;
    logic              ren;
  } sys_req_t;

  // err only meaningful together with ack
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              ack;
    logic              err;
  } sys_rsp_t;

  // Expand byte selects into a bit mask
  function automatic logic [DATA_W-1:0] strb_mask(logic [3:0] wsel);
    logic [DATA_W-1:0] m;
    for (int b = 0; b < 4; b++) begin
      m[b*8 +: 8] = {8{wsel[b]}};
    end
    return m;
  endfunction

endpackage

`default_nettype wire

// File: hdl/ps_sys_top.sv
/*
 * Register side of the processor-system wrapper. AXI slave, bus decoder,
 * GPIO block and interrupt block wired together.
 */

`timescale 1ns/1ps
`default_nettype none

module ps_sys_top #(
  parameter int GPIO_W = 8,
  parameter int IRQ_N  = 4
) (
  input  wire                  clk_i,
  input  wire                  arst_n_i,
  // AXI
  input  wire ps_sys_pkg::axi_aw_t aw_i,
  input  wire ps_sys_pkg::axi_w_t  w_i,
  input  wire ps_sys_pkg::axi_ar_t ar_i,
  input  wire                  bready_i,
  input  wire                  rready_i,
  output logic                 awready_o,
  output logic                 wready_o,
  output logic                 arready_o,
  output ps_sys_pkg::axi_b_t   b_o,
  output ps_sys_pkg::axi_r_t   r_o,
  // GPIO pins
  input  wire [GPIO_W-1:0]     gpio_i,
  output logic [GPIO_W-1:0]    gpio_o,
  output logic [GPIO_W-1:0]    gpio_t_o,
  // Interrupts
  input  wire [IRQ_N-1:0]      irq_src_i,
  output logic                 irq_o
);

  ps_sys_pkg::sys_req_t sys_req;
  ps_sys_pkg::sys_rsp_t sys_rsp;
  ps_sys_pkg::sys_req_t gpio_req;
  ps_sys_pkg::sys_rsp_t gpio_rsp;
  ps_sys_pkg::sys_req_t irq_req;
  ps_sys_pkg::sys_rsp_t irq_rsp;
  logic                 decerr;

  //////////////////////////////////////////////////////////////////////////
  // AXI to system bus
  //////////////////////////////////////////////////////////////////////////

  axi_sys_slave axi_slave0 (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .aw_i      (aw_i),
    .w_i       (w_i),
    .ar_i      (ar_i),
    .bready_i  (bready_i),
    .rready_i  (rready_i),
    .awready_o (awready_o),
    .wready_o  (wready_o),
    .arready_o (arready_o),
    .b_o       (b_o),
    .r_o       (r_o),
    .sys_req_o (sys_req),
    .sys_rsp_i (sys_rsp),
    .decerr_i  (decerr)
  );

  sys_bus_decoder decoder0 (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (sys_req),
    .rsp_o      (sys_rsp),
    .gpio_req_o (gpio_req),
    .irq_req_o  (irq_req),
    .gpio_rsp_i (gpio_rsp),
    .irq_rsp_i  (irq_rsp),
    .decerr_o   (decerr)
  );

  //////////////////////////////////////////////////////////////////////////
  // Register blocks
  //////////////////////////////////////////////////////////////////////////

  gpio_regs #(
    .GPIO_W (GPIO_W)
  ) gpio0 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (gpio_req),
    .rsp_o    (gpio_rsp),
    .gpio_i   (gpio_i),
    .gpio_o   (gpio_o),
    .gpio_t_o (gpio_t_o)
  );

  irq_ctrl #(
    .IRQ_N (IRQ_N)
  ) irq0 (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (irq_req),
    .rsp_o     (irq_rsp),
    .irq_src_i (irq_src_i),
    .irq_o     (irq_o)
  );

endmodule

`default_nettype wire

// File: hdl/sys_bus_decoder.sv
/*
 * System-bus decoder. Steers strobes to the GPIO or interrupt block by
 * address bits 19:16 and merges their answers. Unmapped regions get a
 * registered error ack, flagged on decerr_o.
 */

`timescale 1ns/1ps
`default_nettype none

module sys_bus_decoder (
  input  wire                  clk_i,
  input  wire                  arst_n_i,
  // From the AXI slave
  input  wire ps_sys_pkg::sys_req_t req_i,
  output ps_sys_pkg::sys_rsp_t rsp_o,
  // Register blocks
  output ps_sys_pkg::sys_req_t gpio_req_o,
  output ps_sys_pkg::sys_req_t irq_req_o,
  input  wire ps_sys_pkg::sys_rsp_t gpio_rsp_i,
  input  wire ps_sys_pkg::sys_rsp_t irq_rsp_i,
  output logic                 decerr_o
);

  logic [3:0] region;
  logic       sel_gpio;
  logic       sel_irq;
  logic       unmapped;
  logic       dec_ack_q;

  assign region   = req_i.addr[19:16];
  assign sel_gpio = (region == ps_sys_pkg::REGION_GPIO);
  assign sel_irq  = (region == ps_sys_pkg::REGION_IRQ);
  assign unmapped = !sel_gpio && !sel_irq;

  // Payload goes everywhere, strobes only to the selected block
  always_comb begin
    gpio_req_o     = req_i;
    gpio_req_o.wen = req_i.wen && sel_gpio;
    gpio_req_o.ren = req_i.ren && sel_gpio;
    irq_req_o      = req_i;
    irq_req_o.wen  = req_i.wen && sel_irq;
    irq_req_o.ren  = req_i.ren && sel_irq;
  end

  // Error ack one cycle after a strobe to nowhere
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_ack_q <= 1'b0;
    end else begin
      dec_ack_q <= (req_i.wen || req_i.ren) && unmapped;
    end
  end

  // Only one source acks at a time
  always_comb begin
    rsp_o.ack = gpio_rsp_i.ack || irq_rsp_i.ack || dec_ack_q;
    rsp_o.err = (gpio_rsp_i.ack && gpio_rsp_i.err)
             || (irq_rsp_i.ack && irq_rsp_i.err)
             || dec_ack_q;
    // Zero data for the unmapped case
    rsp_o.rdata = '0;
    if (gpio_rsp_i.ack) begin
      rsp_o.rdata = gpio_rsp_i.rdata;
    end else if (irq_rsp_i.ack) begin
      rsp_o.rdata = irq_rsp_i.rdata;
    end
  end

  assign decerr_o = dec_ack_q;

endmodule

`default_nettype wire

// File: ps_sys_top.f
hdl/ps_sys_pkg.sv
hdl/axi_sys_slave.sv
hdl/sys_bus_decoder.sv
hdl/gpio_regs.sv
hdl/irq_ctrl.sv
hdl/ps_sys_top.sv
dv/tb_clock.sv
dv/ps_sys_properties.sv
dv/ps_sys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module ps_sys_tb \
  -f ps_sys_top.f \
  --Mdir obj_dir -o ps_sys_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed"
  exit "$status"
fi

./obj_dir/ps_sys_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed"
  exit "$status"
fi

exit 0
